//--- hdl/video_pkg.sv
// Video mode enumeration, raster window tables and frame timing constants
package video_pkg;

    // Whole frame in pixel clocks and lines
    localparam logic [8:0] h_total = 9'd448;
    localparam logic [8:0] v_total = 9'd320;

    // Sync pulses sit at the start of the blanking area
    localparam logic [8:0] hsync_len = 9'd32;
    localparam logic [8:0] vsync_len = 9'd4;

    // One DRAM word covers eight columns
    localparam logic [8:0] slot_len = 9'd8;

    // Fetch lead and tail against the visible window
    localparam logic [8:0] go_lead_lo = 9'd16;
    localparam logic [8:0] go_tail_lo = 9'd18;
    localparam logic [8:0] go_lead_hi = 9'd8;
    localparam logic [8:0] go_tail_hi = 9'd10;

    typedef enum logic [2:0] {
        mode_zx       = 3'd0,
        mode_giga     = 3'd1,
        mode_rsv2     = 3'd2,
        mode_rsv3     = 3'd3,
        mode_rsv4     = 3'd4,
        mode_zx_hires = 3'd5,
        mode_256c     = 3'd6,
        mode_text     = 3'd7
    } vmode_t;

    // Raster windows by resolution code
    // 0 is 256x192, 1 is 320x200, 2 is 320x240, 3 is 360x288
    localparam logic [8:0] hp_beg_tab [4] = '{9'd140, 9'd108, 9'd108, 9'd88};
    localparam logic [8:0] hp_end_tab [4] = '{9'd396, 9'd428, 9'd428, 9'd448};
    localparam logic [8:0] vp_beg_tab [4] = '{9'd80, 9'd76, 9'd56, 9'd32};
    localparam logic [8:0] vp_end_tab [4] = '{9'd272, 9'd276, 9'd296, 9'd320};

    // DRAM share code per mode, index is the mode number
    localparam logic [1:0] bw_tab [8] = '{
        2'd0, 2'd1, 2'd1, 2'd2, 2'd3, 2'd1, 2'd2, 2'd2
    };

    // Double pixel rate in ZX hi-res and text
    localparam logic [7:0] hires_mask = 8'b1010_0000;

endpackage

//--- hdl/dram_pkg.sv
// DRAM bus widths, arbiter state enumeration and video credit constants
package dram_pkg;

    // Word address and data of the external DRAM port
    localparam int addr_w = 21;
    localparam int data_w = 16;

    typedef enum logic [1:0] {
        arb_idle,
        arb_video,
        arb_cpu
    } arb_state_t;

    // Credit counter holds up to eight video grants
    localparam int credit_w = 4;

    // Shifted by the bandwidth code to give the full credit
    localparam logic [credit_w-1:0] credit_unit = 1;

endpackage

//--- hdl/video_mode.sv
// Video mode decoder for raster window, fetch window, DRAM share and display address
module video_mode import video_pkg::*, dram_pkg::*; (
    input  logic [7:0]        vconfig,
    input  logic [7:0]        scr_page,
    input  logic [8:0]        cnt_col,
    input  logic [8:0]        cnt_row,
    output logic [8:0]        hpix_beg,
    output logic [8:0]        hpix_end,
    output logic [8:0]        vpix_beg,
    output logic [8:0]        vpix_end,
    output logic [8:0]        go_beg,
    output logic [8:0]        go_end,
    output logic              hires,
    output logic [addr_w-1:0] video_addr,
    output logic [1:0]        video_bw
);

    vmode_t            vmod;
    logic [1:0]        rres;
    logic [addr_w-1:0] addr_zx_gfx;
    logic [addr_w-1:0] addr_zx_atr;
    logic [addr_w-1:0] addr_zx;
    logic [addr_w-1:0] addr_256c;

    assign vmod = vmode_t'(vconfig[2:0]);
    assign rres = vconfig[4:3];

    assign hpix_beg = hp_beg_tab[rres];
    assign hpix_end = hp_end_tab[rres];
    assign vpix_beg = vp_beg_tab[rres];
    assign vpix_end = vp_end_tab[rres];

    assign video_bw = bw_tab[vconfig[2:0]];
    assign hires    = hires_mask[vconfig[2:0]];

    // ZX bitmap row order is third, scanline, character row
    assign addr_zx_gfx = {scr_page, 1'b0, cnt_row[7:6], cnt_row[2:0], cnt_row[5:3],
                          cnt_col[4:1]};
    assign addr_zx_atr = {scr_page, 4'b0110, cnt_row[7:3], cnt_col[4:1]};

    // Even words are attributes, odd words are bitmap
    assign addr_zx = cnt_col[0] ? addr_zx_gfx : addr_zx_atr;

    // Page bit 7 falls off the top of the 21-bit word address
    assign addr_256c = {scr_page[6:4], cnt_row, cnt_col};

    always_comb begin
        go_beg     = hpix_beg - go_lead_lo;
        go_end     = hpix_end - go_tail_lo;
        video_addr = '0;
        case (vmod)
            mode_zx, mode_rsv2, mode_rsv3, mode_rsv4: begin
                video_addr = addr_zx;
            end
            mode_zx_hires: begin
                video_addr = addr_zx;
                go_beg     = hpix_beg - go_lead_hi;
                go_end     = hpix_end - go_tail_hi;
            end
            mode_256c: begin
                video_addr = addr_256c;
            end
            mode_text: begin
                // Text layout not decoded yet
                go_beg = hpix_beg - go_lead_hi;
                go_end = hpix_end - go_tail_hi;
            end
            default: begin
                video_addr = '0;
            end
        endcase
    end

    // Every raster table entry must open before it closes
    assert final ((hpix_beg < hpix_end) && (vpix_beg < vpix_end))
        else $error("video_mode: empty visible window for rres %0d", rres);

endmodule

//--- hdl/video_sync.sv
// Raster counters with registered sync pulses, visibility flags and active row index
module video_sync import video_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic [8:0] vpix_beg,
    input  logic [8:0] vpix_end,
    input  logic [8:0] hpix_beg,
    input  logic [8:0] hpix_end,
    output logic [8:0] col,
    output logic [8:0] row,
    output logic [8:0] act_row,
    output logic       row_vis,
    output logic       pix_active,
    output logic       hsync,
    output logic       vsync
);

    logic [8:0] cnt_h;
    logic [8:0] cnt_v;
    logic       line_end;
    logic       h_vis;
    logic       v_vis;

    assign line_end = (cnt_h == h_total - 9'd1);
    assign h_vis    = (cnt_h >= hpix_beg) && (cnt_h < hpix_end);
    assign v_vis    = (cnt_v >= vpix_beg) && (cnt_v < vpix_end);

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_h <= '0;
            cnt_v <= '0;
        end else if (line_end) begin
            cnt_h <= '0;
            cnt_v <= (cnt_v == v_total - 9'd1) ? 9'd0 : cnt_v + 9'd1;
        end else begin
            cnt_h <= cnt_h + 9'd1;
        end
    end

    // Everything below lags the counters by one clock
    always_ff @(posedge clk) begin
        if (rst) begin
            col        <= '0;
            row        <= '0;
            act_row    <= '0;
            row_vis    <= 1'b0;
            pix_active <= 1'b0;
            hsync      <= 1'b0;
            vsync      <= 1'b0;
        end else begin
            col        <= cnt_h;
            row        <= cnt_v;
            act_row    <= v_vis ? cnt_v - vpix_beg : 9'd0;
            row_vis    <= v_vis;
            pix_active <= h_vis && v_vis;
            hsync      <= (cnt_h < hsync_len);
            vsync      <= (cnt_v < vsync_len);
        end
    end

    // Line wraps straight from the last column back to zero
    assert property (@(posedge clk) disable iff (rst)
        (col == h_total - 9'd1) |=> (col == 9'd0));

endmodule

//--- hdl/video_fetch.sv
// Fetch slot scheduler and four-phase read master with per-line word counter
module video_fetch import video_pkg::*, dram_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic [8:0]        col,
    input  logic              row_vis,
    input  logic [8:0]        go_beg,
    input  logic [8:0]        go_end,
    input  logic [addr_w-1:0] video_addr,
    output logic [8:0]        cnt_col,
    output logic              vid_req,
    input  logic              vid_ack,
    output logic [addr_w-1:0] vid_addr,
    input  logic [data_w-1:0] vid_rdata,
    output logic [data_w-1:0] pix_data,
    output logic              pix_valid
);

    typedef enum logic [1:0] {
        f_idle,
        f_wait,
        f_drop
    } fetch_state_t;

    fetch_state_t state;
    logic [8:0]   owed;
    logic [8:0]   slot_off;
    logic         slot_hit;
    logic         word_done;
    logic         start;

    assign slot_off = col - go_beg;
    assign slot_hit = row_vis && (col >= go_beg) && (col < go_end) &&
                      ((slot_off % slot_len) == 9'd0);

    assign start     = (state == f_idle) && (owed != 9'd0);
    assign word_done = (state == f_wait) && vid_ack;

    // Words still owed to this line
    always_ff @(posedge clk) begin
        if (rst) begin
            owed <= '0;
        end else begin
            owed <= owed + {8'd0, slot_hit} - {8'd0, word_done};
        end
    end

    always_ff @(posedge clk) begin
        if (rst || (col == 9'd0)) begin
            cnt_col <= '0;
        end else if (word_done) begin
            cnt_col <= cnt_col + 9'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= f_idle;
            vid_req   <= 1'b0;
            pix_valid <= 1'b0;
        end else begin
            pix_valid <= 1'b0;
            case (state)
                f_idle: begin
                    if (start) begin
                        vid_req <= 1'b1;
                        state   <= f_wait;
                    end
                end
                f_wait: begin
                    if (vid_ack) begin
                        vid_req   <= 1'b0;
                        pix_valid <= 1'b1;
                        state     <= f_drop;
                    end
                end
                // Hold off until the slave has released ack
                f_drop: begin
                    if (!vid_ack) begin
                        state <= f_idle;
                    end
                end
                default: state <= f_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            vid_addr <= video_addr;
        end
        if (word_done) begin
            pix_data <= vid_rdata;
        end
    end

    // All owed words of a line land before the next line starts
    assert property (@(posedge clk) disable iff (rst) (col == 9'd0) |-> (owed == 9'd0));

endmodule

//--- hdl/dram_arbiter.sv
// DRAM port arbiter for video reads and CPU writes with credit-limited video priority
module dram_arbiter import dram_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic [1:0]        video_bw,
    input  logic              vid_req,
    output logic              vid_ack,
    input  logic [addr_w-1:0] vid_addr,
    output logic [data_w-1:0] vid_rdata,
    input  logic              cpu_req,
    output logic              cpu_ack,
    input  logic [addr_w-1:0] cpu_addr,
    input  logic [data_w-1:0] cpu_wdata,
    output logic              dram_req,
    input  logic              dram_ack,
    output logic              dram_we,
    output logic [addr_w-1:0] dram_addr,
    output logic [data_w-1:0] dram_wdata,
    input  logic [data_w-1:0] dram_rdata
);

    arb_state_t          state;
    logic [credit_w-1:0] credit;
    logic [credit_w-1:0] credit_full;
    logic                grant_vid;
    logic                grant_cpu;
    logic                owner_req;
    logic                can_grant;

    assign credit_full = credit_unit << video_bw;
    assign can_grant   = (state == arb_idle) && !dram_ack;

    // Video keeps priority until its credit runs out
    assign grant_vid = vid_req && (!cpu_req || (credit != '0));
    assign grant_cpu = cpu_req && !grant_vid;

    assign owner_req = (state == arb_video) ? vid_req : cpu_req;

    assign vid_ack   = (state == arb_video) && dram_ack;
    assign cpu_ack   = (state == arb_cpu) && dram_ack;
    assign vid_rdata = dram_rdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= arb_idle;
            dram_req <= 1'b0;
            dram_we  <= 1'b0;
            credit   <= credit_full;
        end else if (can_grant) begin
            if (!cpu_req) begin
                credit <= credit_full;
            end
            if (grant_vid) begin
                state    <= arb_video;
                dram_req <= 1'b1;
                dram_we  <= 1'b0;
                if (cpu_req) begin
                    credit <= credit - credit_unit;
                end
            end else if (grant_cpu) begin
                state    <= arb_cpu;
                dram_req <= 1'b1;
                dram_we  <= 1'b1;
                credit   <= credit_full;
            end
        end else if (state != arb_idle) begin
            // Req falls once with the master and stays low
            dram_req <= dram_req && owner_req;
            if (!dram_req && !dram_ack) begin
                state <= arb_idle;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (can_grant && grant_vid) begin
            dram_addr <= vid_addr;
        end else if (can_grant && grant_cpu) begin
            dram_addr  <= cpu_addr;
            dram_wdata <= cpu_wdata;
        end
    end

    // DRAM answers only a granted transfer
    assert property (@(posedge clk) disable iff (rst) dram_ack |-> (state != arb_idle));
    assert property (@(posedge clk) disable iff (rst) $rose(dram_ack) |-> dram_req);

endmodule

//--- hdl/video_top.sv
// Video fetch subsystem top with raster timing, mode decoder, fetch engine and DRAM arbiter
module video_top import dram_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic [7:0]        vconfig,
    input  logic [7:0]        scr_page,
    input  logic              cpu_req,
    output logic              cpu_ack,
    input  logic [addr_w-1:0] cpu_addr,
    input  logic [data_w-1:0] cpu_wdata,
    output logic              dram_req,
    input  logic              dram_ack,
    output logic              dram_we,
    output logic [addr_w-1:0] dram_addr,
    output logic [data_w-1:0] dram_wdata,
    input  logic [data_w-1:0] dram_rdata,
    output logic [data_w-1:0] pix_data,
    output logic              pix_valid,
    output logic              pix_active,
    output logic              hsync,
    output logic              vsync,
    output logic              hires
);

    logic [8:0]        col;
    logic [8:0]        act_row;
    logic              row_vis;
    logic [8:0]        hpix_beg;
    logic [8:0]        hpix_end;
    logic [8:0]        vpix_beg;
    logic [8:0]        vpix_end;
    logic [8:0]        go_beg;
    logic [8:0]        go_end;
    logic [8:0]        cnt_col;
    logic [addr_w-1:0] video_addr;
    logic [1:0]        video_bw;
    logic              vid_req;
    logic              vid_ack;
    logic [addr_w-1:0] vid_addr;
    logic [data_w-1:0] vid_rdata;

    video_sync u_sync (
        .clk, .rst,
        .vpix_beg, .vpix_end, .hpix_beg, .hpix_end,
        .col, .row(), .act_row, .row_vis,
        .pix_active, .hsync, .vsync
    );

    // Address follows the visible row and the words fetched so far
    video_mode u_mode (
        .vconfig, .scr_page,
        .cnt_col, .cnt_row(act_row),
        .hpix_beg, .hpix_end, .vpix_beg, .vpix_end,
        .go_beg, .go_end,
        .hires, .video_addr, .video_bw
    );

    video_fetch u_fetch (
        .clk, .rst,
        .col, .row_vis, .go_beg, .go_end, .video_addr,
        .cnt_col,
        .vid_req, .vid_ack, .vid_addr, .vid_rdata,
        .pix_data, .pix_valid
    );

    dram_arbiter u_arb (
        .clk, .rst, .video_bw,
        .vid_req, .vid_ack, .vid_addr, .vid_rdata,
        .cpu_req, .cpu_ack, .cpu_addr, .cpu_wdata,
        .dram_req, .dram_ack, .dram_we, .dram_addr, .dram_wdata, .dram_rdata
    );

endmodule

//--- testbench/dram_model.sv
// Behavioural DRAM responder with four-phase handshake and address-derived read data
module dram_model import dram_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              dram_req,
    output logic              dram_ack,
    input  logic [addr_w-1:0] dram_addr,
    output logic [data_w-1:0] dram_rdata
);
    timeunit 1ns;
    timeprecision 1ps;

    // Clocks from req seen to ack raised
    localparam int ack_wait = 1;

    int wait_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            dram_ack   <= 1'b0;
            dram_rdata <= '0;
            wait_cnt   <= 0;
        end else if (dram_req && !dram_ack) begin
            if (wait_cnt + 1 >= ack_wait) begin
                dram_ack   <= 1'b1;
                dram_rdata <= dram_addr[15:0] ^ {dram_addr[20:16], dram_addr[20:10]} ^ 16'h3c5a;
                wait_cnt   <= 0;
            end else begin
                wait_cnt <= wait_cnt + 1;
            end
        end else if (!dram_req && dram_ack) begin
            dram_ack <= 1'b0;
        end
    end

endmodule

//--- testbench/video_tb.sv
// Testbench for the video fetch subsystem with reference address and window checks
module video_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int hb_ref [4] = '{140, 108, 108, 88};
    localparam int he_ref [4] = '{396, 428, 428, 448};
    localparam int vb_ref [4] = '{80, 76, 56, 32};
    localparam int ve_ref [4] = '{272, 276, 296, 320};
    localparam int bw_ref [8] = '{0, 1, 1, 2, 3, 1, 2, 2};

    logic        clk = 1'b0;
    logic        rst;
    logic [7:0]  vconfig, scr_page;
    logic        cpu_req, cpu_ack, dram_req, dram_ack, dram_we;
    logic [20:0] cpu_addr, dram_addr;
    logic [15:0] cpu_wdata, dram_wdata, dram_rdata, pix_data;
    logic        pix_valid, pix_active, hsync, vsync, hires;
    logic        hsync_q, vsync_q, req_q;
    int          line = -1;
    int          words, pix_cnt, frame_no, vids_since;
    bit          cfg_ok, wr_seen;
    logic [20:0] rd_q [$];

    always #20 clk = ~clk;

    video_top uut (.*);
    dram_model u_mem (.clk, .rst, .dram_req, .dram_ack, .dram_addr, .dram_rdata);

    function automatic logic [15:0] mem_word(logic [20:0] a);
        return a[15:0] ^ {a[20:16], a[20:10]} ^ 16'h3c5a;
    endfunction

    // Expected word address for word k of visible row r
    function automatic logic [20:0] exp_addr(logic [7:0] cfg, logic [7:0] pg, logic [8:0] r,
                                             logic [8:0] k);
        case (cfg[2:0])
            3'd0, 3'd2, 3'd3, 3'd4, 3'd5:
                return k[0] ? {pg, 1'b0, r[7:6], r[2:0], r[5:3], k[4:1]}
                            : {pg, 4'b0110, r[7:3], k[4:1]};
            3'd6: return {pg[6:4], r, k};
            default: return 21'd0;
        endcase
    endfunction

    function automatic bit is_hires(logic [7:0] cfg);
        return (cfg[2:0] == 3'd5) || (cfg[2:0] == 3'd7);
    endfunction

    function automatic int slot_count(logic [7:0] cfg);
        int gb;
        int ge;
        gb = hb_ref[cfg[4:3]] - (is_hires(cfg) ? 8 : 16);
        ge = he_ref[cfg[4:3]] - (is_hires(cfg) ? 10 : 18);
        return (ge - gb + 7) / 8;
    endfunction

    task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    task automatic fail_now(string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1);
    endtask

    // Monitor and checker, sampled away from the driving edge
    always @(negedge clk) begin
        if (!rst) begin
            if (hsync && !hsync_q) begin
                if (line >= vb_ref[vconfig[4:3]] && line < ve_ref[vconfig[4:3]])
                    check_val("reads_per_line", words, slot_count(vconfig));
                if (vsync && !vsync_q) begin
                    if (cfg_ok)
                        check_val("pix_active_count", pix_cnt,
                                  (he_ref[vconfig[4:3]] - hb_ref[vconfig[4:3]]) *
                                  (ve_ref[vconfig[4:3]] - vb_ref[vconfig[4:3]]));
                    line     = 0;
                    cfg_ok   = 1;
                    pix_cnt  = 0;
                    frame_no = frame_no + 1;
                end else if (line >= 0) begin
                    line = line + 1;
                end
                words = 0;
            end
            if (pix_active)
                pix_cnt = pix_cnt + 1;
            if (dram_req && !req_q) begin
                if (!dram_we) begin
                    if (line >= 0)
                        check_val("dram_addr", dram_addr, exp_addr(vconfig, scr_page,
                                  line - vb_ref[vconfig[4:3]], words));
                    rd_q.push_back(dram_addr);
                    words = words + 1;
                    if (cpu_req && !wr_seen)
                        vids_since = vids_since + 1;
                end else begin
                    check_val("dram_addr", dram_addr, cpu_addr);
                    check_val("dram_wdata", dram_wdata, cpu_wdata);
                    if (vids_since > (1 << bw_ref[vconfig[2:0]]))
                        fail_now("Too many video reads while a CPU write waited");
                    wr_seen = 1;
                end
            end
            if (pix_valid) begin
                if (rd_q.size() == 0)
                    fail_now("Pixel word arrived without a matching DRAM read");
                check_val("pix_data", pix_data, mem_word(rd_q.pop_front()));
            end
        end
        hsync_q = hsync;
        vsync_q = vsync;
        req_q   = dram_req;
    end

    task automatic wait_frame();
        int start;
        int n;
        start = frame_no;
        n = 0;
        while (frame_no == start) begin
            @(posedge clk);
            n++;
            if (n > 150000)
                fail_now("Timeout waiting for the next frame");
        end
    endtask

    // Change mode at the start of a frame, then run one full checked frame
    task automatic run_mode(logic [7:0] cfg, bit with_cpu);
        int n;
        int start;
        int loops;
        wait_frame();
        vconfig  <= cfg;
        scr_page <= 8'($urandom);
        cfg_ok   = 0;
        @(negedge clk);
        check_val("hires", hires, is_hires(cfg));
        start = frame_no;
        loops = 0;
        while (frame_no < start + 2) begin
            loops++;
            if (loops > 10000)
                fail_now("Timeout waiting for two frames in the new mode");
            if (with_cpu) begin
                repeat (60 + $urandom % 60) @(posedge clk);
                cpu_addr   <= 21'($urandom);
                cpu_wdata  <= 16'($urandom);
                cpu_req    <= 1'b1;
                wr_seen    = 0;
                vids_since = 0;
                n = 0;
                do begin
                    @(posedge clk);
                    n++;
                    if (n > 200)
                        fail_now("Timeout waiting for the CPU write acknowledge");
                end while (!cpu_ack);
                if (!wr_seen)
                    fail_now("CPU write acknowledged without a DRAM write");
                cpu_req <= 1'b0;
                n = 0;
                do begin
                    @(posedge clk);
                    n++;
                    if (n > 200)
                        fail_now("Timeout waiting for the CPU acknowledge to drop");
                end while (cpu_ack);
            end else begin
                wait_frame();
            end
        end
    endtask

    initial begin
        void'($urandom(32'he621));
        rst       = 1'b1;
        vconfig   = 8'h00;
        scr_page  = 8'h00;
        cpu_req   = 1'b0;
        cpu_addr  = '0;
        cpu_wdata = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        // Outputs still at reset values before the counters advance
        @(negedge clk);
        check_val("dram_req", dram_req, 0);
        check_val("cpu_ack", cpu_ack, 0);
        check_val("pix_valid", pix_valid, 0);
        check_val("hsync", hsync, 0);
        check_val("vsync", vsync, 0);
        run_mode(8'h00, 0);
        run_mode(8'h06, 0);
        run_mode(8'h05, 0);
        run_mode(8'h07, 0);
        run_mode(8'h08, 0);
        run_mode(8'h10, 0);
        run_mode(8'h18, 0);
        run_mode(8'h00, 1);
        run_mode(8'h06, 1);
        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- files.f
hdl/video_pkg.sv
hdl/dram_pkg.sv
hdl/video_mode.sv
hdl/video_sync.sv
hdl/video_fetch.sv
hdl/dram_arbiter.sv
hdl/video_top.sv
testbench/dram_model.sv
testbench/video_tb.sv

//--- Bender.yml
package:
  name: video_fetch

sources:
  - hdl/video_pkg.sv
  - hdl/dram_pkg.sv
  - hdl/video_mode.sv
  - hdl/video_sync.sv
  - hdl/video_fetch.sv
  - hdl/dram_arbiter.sv
  - hdl/video_top.sv
  - target: test
    files:
      - testbench/dram_model.sv
      - testbench/video_tb.sv
